// ==== lockstep_pkg.sv ====
// Lockstep checker package with offsets, bus widths, integrity code masks and core beat types
package lockstep_pkg;

  //////////////////////////////////////////////////////////////////////
  // Lockstep timing
  //////////////////////////////////////////////////////////////////////

  // Cycles the shadow core trails the main core
  localparam int unsigned LOCKSTEP_OFFSET = 2;

  // Main outputs wait one extra cycle for the shadow output register
  localparam int unsigned OUT_DELAY = LOCKSTEP_OFFSET + 1;

  localparam int unsigned RST_CNT_W = (LOCKSTEP_OFFSET > 1) ? $clog2(LOCKSTEP_OFFSET) : 1;

  //////////////////////////////////////////////////////////////////////
  // Bus and integrity code
  //////////////////////////////////////////////////////////////////////

  localparam int unsigned DATA_W = 32;
  localparam int unsigned INTG_W = 7;

  // Code bit k is the parity of the data bits selected by mask k
  localparam logic [DATA_W-1:0] INTG_MASKS [INTG_W] = '{
    32'h2606_BD25,
    32'hDEBA_8050,
    32'h413D_89AA,
    32'h3123_4ED1,
    32'hC2C1_323B,
    32'h2DCC_624C,
    32'h9850_5586
  };

  // Inverted code, all-zero data carries a nonzero code
  localparam logic [INTG_W-1:0] INTG_INV = 7'h2A;

  //////////////////////////////////////////////////////////////////////
  // Core opcodes and beats
  //////////////////////////////////////////////////////////////////////

  typedef enum logic [2:0] {
    OP_NOP   = 3'd0,
    OP_LOAD  = 3'd1,
    OP_ADD   = 3'd2,
    OP_SUB   = 3'd3,
    OP_XOR   = 3'd4,
    OP_STORE = 3'd5
  } op_e;

  // One read beat into the core
  typedef struct packed {
    logic              rvalid;
    op_e               op;
    logic [DATA_W-1:0] rdata;
  } core_in_t;

  // Registered core outputs
  typedef struct packed {
    logic [DATA_W-1:0] acc;
    logic              wreq;
    logic [DATA_W-1:0] wdata;
  } core_out_t;

endpackage

// ==== lockstep_reset_seq.sv ====
// Holds the shadow core in reset for the lockstep offset, then enables output comparison
module lockstep_reset_seq import lockstep_pkg::*; (
  input  logic clk_i,
  input  logic rst_ni,
  output logic shadow_rst_no,
  output logic cmp_en_o
);

  logic [RST_CNT_W-1:0] cnt_d, cnt_q;
  logic                 set_d, set_q;
  logic                 cmp_en_q;

  // Counter stops once the release point is reached
  assign set_d = (cnt_q == RST_CNT_W'(LOCKSTEP_OFFSET - 1));
  assign cnt_d = set_d ? cnt_q : cnt_q + RST_CNT_W'(1);

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      cnt_q    <= '0;
      set_q    <= 1'b0;
      cmp_en_q <= 1'b0;
    end else begin
      cnt_q    <= cnt_d;
      set_q    <= set_d;
      // Compare starts one cycle after the shadow core leaves reset
      cmp_en_q <= set_q;
    end
  end

  assign shadow_rst_no = set_q;
  assign cmp_en_o      = cmp_en_q;

endmodule

// ==== lockstep_input_delay.sv ====
// Delays main core input beats by the lockstep offset to feed the shadow core
module lockstep_input_delay import lockstep_pkg::*; (
  input  logic              clk_i,
  input  logic              rst_ni,
  input  core_in_t          beat_i,
  input  logic [INTG_W-1:0] intg_i,
  output core_in_t          beat_first_o,
  output logic [INTG_W-1:0] intg_first_o,
  output core_in_t          beat_delayed_o
);

  // Stage 0 is the newest beat
  core_in_t [LOCKSTEP_OFFSET-1:0] stage_q;
  logic [INTG_W-1:0]              intg_q;

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      stage_q <= '0;
      intg_q  <= '0;
    end else begin
      stage_q[0] <= beat_i;
      for (int unsigned i = 1; i < LOCKSTEP_OFFSET; i++) begin
        stage_q[i] <= stage_q[i-1];
      end
      // Lines up with stage 0 for the bus check
      intg_q <= intg_i;
    end
  end

  assign beat_first_o   = stage_q[0];
  assign intg_first_o   = intg_q;
  assign beat_delayed_o = stage_q[LOCKSTEP_OFFSET-1];

endmodule

// ==== acc_core.sv ====
// Small accumulator core with load, arithmetic, xor and store operations on read beats
module acc_core import lockstep_pkg::*; (
  input  logic      clk_i,
  input  logic      rst_ni,
  input  core_in_t  beat_i,
  output core_out_t out_o
);

  core_out_t out_d, out_q;

  //////////////////////////////////////////////////////////////////////
  // Next state
  //////////////////////////////////////////////////////////////////////

  always_comb begin
    out_d       = out_q;
    out_d.wreq  = 1'b0;

    if (beat_i.rvalid) begin
      unique case (beat_i.op)
        OP_LOAD: begin
          out_d.acc = beat_i.rdata;
        end
        OP_ADD: begin
          out_d.acc = out_q.acc + beat_i.rdata;
        end
        OP_SUB: begin
          out_d.acc = out_q.acc - beat_i.rdata;
        end
        OP_XOR: begin
          out_d.acc = out_q.acc ^ beat_i.rdata;
        end
        OP_STORE: begin
          // Write request lasts one cycle, data stays behind
          out_d.wreq  = 1'b1;
          out_d.wdata = out_q.acc;
        end
        default: begin
          out_d.acc = out_q.acc;
        end
      endcase
    end
  end

  //////////////////////////////////////////////////////////////////////
  // State
  //////////////////////////////////////////////////////////////////////

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      out_q <= '0;
    end else begin
      out_q <= out_d;
    end
  end

  assign out_o = out_q;

endmodule

// ==== bus_intg_check.sv ====
// Checks integrity of registered read beats and encodes integrity for outgoing write data
module bus_intg_check import lockstep_pkg::*; (
  input  core_in_t          beat_i,
  input  logic [INTG_W-1:0] intg_i,
  input  logic [DATA_W-1:0] wdata_i,
  output logic              bus_err_o,
  output logic [INTG_W-1:0] wdata_intg_o
);

  // Parity per mask, then inverted
  function automatic logic [INTG_W-1:0] intg_enc(input logic [DATA_W-1:0] data);
    logic [INTG_W-1:0] code;
    for (int unsigned k = 0; k < INTG_W; k++) begin
      code[k] = ^(data & INTG_MASKS[k]);
    end
    return code ^ INTG_INV;
  endfunction

  logic [INTG_W-1:0] rdata_code;

  //////////////////////////////////////////////////////////////////////
  // Read check
  //////////////////////////////////////////////////////////////////////

  assign rdata_code = intg_enc(beat_i.rdata);

  // Code is only meaningful on a valid beat
  assign bus_err_o = beat_i.rvalid & (rdata_code != intg_i);

  //////////////////////////////////////////////////////////////////////
  // Write generation
  //////////////////////////////////////////////////////////////////////

  assign wdata_intg_o = intg_enc(wdata_i);

endmodule

// ==== lockstep_compare.sv ====
// Delays main core outputs, registers shadow outputs and flags any difference between them
module lockstep_compare import lockstep_pkg::*; (
  input  logic      clk_i,
  input  logic      rst_ni,
  input  logic      cmp_en_i,
  input  core_out_t main_out_i,
  input  core_out_t shadow_out_i,
  output logic      mismatch_o
);

  // Entry OUT_DELAY-1 holds the oldest main output
  core_out_t [OUT_DELAY-1:0] main_q;
  core_out_t                 shadow_q;

  //////////////////////////////////////////////////////////////////////
  // Output alignment
  //////////////////////////////////////////////////////////////////////

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      main_q   <= '0;
      shadow_q <= '0;
    end else begin
      main_q[0] <= main_out_i;
      for (int unsigned i = 1; i < OUT_DELAY; i++) begin
        main_q[i] <= main_q[i-1];
      end
      shadow_q <= shadow_out_i;
    end
  end

  //////////////////////////////////////////////////////////////////////
  // Comparison
  //////////////////////////////////////////////////////////////////////

  // Any bit difference counts
  assign mismatch_o = cmp_en_i & (main_q[OUT_DELAY-1] != shadow_q);

endmodule

// ==== lockstep_top.sv ====
// Lockstep checker top level running a shadow accumulator core behind the main core
module lockstep_top import lockstep_pkg::*; (
  input  logic              clk_i,
  input  logic              rst_ni,
  input  core_in_t          core_in_i,
  input  logic [INTG_W-1:0] rdata_intg_i,
  input  core_out_t         main_out_i,
  output logic [INTG_W-1:0] data_wdata_intg_o,
  output logic              alert_major_internal_o,
  output logic              alert_major_bus_o
);

  logic              shadow_rst_n;
  logic              cmp_en;
  core_in_t          beat_first;
  core_in_t          beat_delayed;
  logic [INTG_W-1:0] intg_first;
  core_out_t         shadow_out;

  lockstep_reset_seq u_reset_seq (
    .clk_i        (clk_i),
    .rst_ni       (rst_ni),
    .shadow_rst_no(shadow_rst_n),
    .cmp_en_o     (cmp_en)
  );

  lockstep_input_delay u_input_delay (
    .clk_i         (clk_i),
    .rst_ni        (rst_ni),
    .beat_i        (core_in_i),
    .intg_i        (rdata_intg_i),
    .beat_first_o  (beat_first),
    .intg_first_o  (intg_first),
    .beat_delayed_o(beat_delayed)
  );

  acc_core u_shadow_core (
    .clk_i (clk_i),
    .rst_ni(shadow_rst_n),
    .beat_i(beat_delayed),
    .out_o (shadow_out)
  );

  bus_intg_check u_bus_intg_check (
    .beat_i      (beat_first),
    .intg_i      (intg_first),
    .wdata_i     (main_out_i.wdata),
    .bus_err_o   (alert_major_bus_o),
    .wdata_intg_o(data_wdata_intg_o)
  );

  lockstep_compare u_compare (
    .clk_i       (clk_i),
    .rst_ni      (rst_ni),
    .cmp_en_i    (cmp_en),
    .main_out_i  (main_out_i),
    .shadow_out_i(shadow_out),
    .mismatch_o  (alert_major_internal_o)
  );

endmodule

// ==== tb_lockstep.sv ====
// Testbench for the lockstep checker with a main core model, fault injection and alert prediction
module tb_lockstep import lockstep_pkg::*; ();

  localparam int MAX_CYCLES    = 1000;
  localparam int ALERT_TIMEOUT = 8;

  logic              clk_i;
  logic              rst_ni;
  core_in_t          core_in;
  logic [INTG_W-1:0] rdata_intg;
  core_out_t         main_out;
  logic [INTG_W-1:0] data_wdata_intg_o;
  logic              alert_major_internal_o;
  logic              alert_major_bus_o;

  // Main core model state and checker bookkeeping
  core_out_t main_ref;
  integer    seed = 32289;
  int        cyc = 0;
  int        rst_edges = 0;
  logic      diff_q[$];
  logic      bus_bad_q;

  lockstep_top dut (
    .clk_i                 (clk_i),
    .rst_ni                (rst_ni),
    .core_in_i             (core_in),
    .rdata_intg_i          (rdata_intg),
    .main_out_i            (main_out),
    .data_wdata_intg_o     (data_wdata_intg_o),
    .alert_major_internal_o(alert_major_internal_o),
    .alert_major_bus_o     (alert_major_bus_o)
  );

  initial begin
    clk_i = 1'b0;
    forever #10 clk_i = ~clk_i;
  end

  //////////////////////////////////////////////////////////////////////
  // Reference functions
  //////////////////////////////////////////////////////////////////////

  function automatic core_out_t core_next(input core_out_t cur, input core_in_t b);
    core_out_t nxt;
    nxt      = cur;
    nxt.wreq = 1'b0;
    if (b.rvalid) begin
      case (b.op)
        OP_LOAD:  nxt.acc = b.rdata;
        OP_ADD:   nxt.acc = cur.acc + b.rdata;
        OP_SUB:   nxt.acc = cur.acc - b.rdata;
        OP_XOR:   nxt.acc = cur.acc ^ b.rdata;
        OP_STORE: begin
          nxt.wreq  = 1'b1;
          nxt.wdata = cur.acc;
        end
        default: ;
      endcase
    end
    return nxt;
  endfunction

  function automatic logic [INTG_W-1:0] intg_encode(input logic [DATA_W-1:0] data);
    logic [INTG_W-1:0] par;
    for (int k = 0; k < INTG_W; k++) begin
      par[k] = ^(data & INTG_MASKS[k]);
    end
    return par ^ INTG_INV;
  endfunction

  function automatic core_in_t rand_beat();
    core_in_t   b;
    logic [2:0] op_raw;
    op_raw   = 3'({$random(seed)} % 6);
    b.rvalid = 1'b1;
    b.op     = op_e'(op_raw);
    b.rdata  = $random(seed);
    // Zero words now and then
    if ({$random(seed)} % 8 == 0) begin
      b.rdata = '0;
    end
    return b;
  endfunction

  //////////////////////////////////////////////////////////////////////
  // Reporting and driving
  //////////////////////////////////////////////////////////////////////

  task automatic abort_run(input string why);
    $display("%s", why);
    $display("Some tests failed");
    $fatal(1);
  endtask

  task automatic check_val(input string name, input logic [63:0] got, input logic [63:0] exp);
    if (got !== exp) begin
      abort_run($sformatf("Fail at time %0t: %s is %0h, expected %0h", $time, name, got, exp));
    end
  endtask

  // Main core register updates on the edge, new inputs follow 2 units later
  task automatic drive_cycle(input core_in_t beat, input logic [INTG_W-1:0] intg,
                             input core_out_t flip);
    @(posedge clk_i);
    if (!rst_ni) begin
      main_ref = '0;
    end else begin
      main_ref = core_next(main_ref, core_in);
    end
    #2;
    core_in    = beat;
    rdata_intg = intg;
    main_out   = main_ref ^ flip;
    cyc++;
  endtask

  task automatic wait_for_alert(input logic on_bus, input int exp_cyc);
    logic seen;
    int   n;
    seen = 1'b0;
    n    = 0;
    while (!seen && n < ALERT_TIMEOUT) begin
      drive_cycle('0, intg_encode('0), '0);
      @(negedge clk_i);
      seen = on_bus ? alert_major_bus_o : alert_major_internal_o;
      n++;
    end
    if (!seen) begin
      abort_run("Expected alert was not raised before the timeout");
    end else begin
      check_val("alert cycle", cyc, exp_cyc);
    end
  endtask

  //////////////////////////////////////////////////////////////////////
  // Alert prediction and comparison
  //////////////////////////////////////////////////////////////////////

  always @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      rst_edges <= 0;
    end else if (rst_edges < 8) begin
      rst_edges <= rst_edges + 1;
    end
  end

  initial begin
    for (int i = 0; i < OUT_DELAY; i++) begin
      diff_q.push_back(1'b0);
    end
    bus_bad_q = 1'b0;
    forever begin
      @(negedge clk_i);
      check_val("alert_major_internal_o", alert_major_internal_o,
                (rst_edges >= OUT_DELAY) && diff_q[0]);
      check_val("alert_major_bus_o", alert_major_bus_o, (rst_edges >= 1) && bus_bad_q);
      check_val("data_wdata_intg_o", data_wdata_intg_o, intg_encode(main_out.wdata));
      void'(diff_q.pop_front());
      diff_q.push_back(main_out != main_ref);
      bus_bad_q = core_in.rvalid && (rdata_intg != intg_encode(core_in.rdata));
    end
  end

  initial begin
    for (int i = 0; i < MAX_CYCLES; i++) begin
      @(posedge clk_i);
    end
    abort_run("Simulation did not finish within the cycle limit");
  end

  //////////////////////////////////////////////////////////////////////
  // Stimulus
  //////////////////////////////////////////////////////////////////////

  initial begin
    core_in_t  beat;
    core_out_t flip;
    rst_ni     = 1'b0;
    core_in    = '0;
    rdata_intg = '0;
    main_out   = '0;
    main_ref   = '0;

    // Garbage on the main outputs while in reset
    for (int i = 0; i < 4; i++) begin
      flip = {$random(seed), 1'b1, $random(seed)};
      drive_cycle('0, intg_encode('0), flip);
    end
    drive_cycle('0, intg_encode('0), '0);
    rst_ni = 1'b1;
    for (int i = 0; i < OUT_DELAY + 2; i++) begin
      drive_cycle('0, intg_encode('0), '0);
    end

    // Clean random stream
    for (int i = 0; i < 200; i++) begin
      beat = rand_beat();
      drive_cycle(beat, intg_encode(beat.rdata), '0);
    end

    // Store of a zero accumulator
    beat        = '0;
    beat.rvalid = 1'b1;
    beat.op     = OP_LOAD;
    drive_cycle(beat, intg_encode('0), '0);
    beat.op = OP_STORE;
    drive_cycle(beat, intg_encode('0), '0);

    // Output faults on acc and on wreq
    flip        = '0;
    flip.acc[5] = 1'b1;
    drive_cycle('0, intg_encode('0), flip);
    wait_for_alert(1'b0, cyc + OUT_DELAY);
    flip      = '0;
    flip.wreq = 1'b1;
    drive_cycle('0, intg_encode('0), flip);
    wait_for_alert(1'b0, cyc + OUT_DELAY);

    // Bad read code, valid and then ignored
    beat = rand_beat();
    drive_cycle(beat, intg_encode(beat.rdata) ^ 7'h04, '0);
    wait_for_alert(1'b1, cyc + 1);
    beat.rvalid = 1'b0;
    drive_cycle(beat, intg_encode(beat.rdata) ^ 7'h04, '0);
    drive_cycle('0, intg_encode('0), '0);
    @(negedge clk_i);
    check_val("alert_major_bus_o", alert_major_bus_o, 1'b0);

    for (int i = 0; i < OUT_DELAY + 2; i++) begin
      drive_cycle('0, intg_encode('0), '0);
    end
    @(negedge clk_i);

    $display("All tests passed");
    $finish;
  end

endmodule

// ==== flist.f ====
lockstep_pkg.sv
lockstep_reset_seq.sv
lockstep_input_delay.sv
acc_core.sv
bus_intg_check.sv
lockstep_compare.sv
lockstep_top.sv
tb_lockstep.sv
